// File: src/wakeupPkg.sv
//**************************************************************************
// Wakeup pipeline package
// Sizes, vector types, bus structs and the selective flush range check
// that the issue-queue wakeup pipeline shares
//**************************************************************************

`default_nettype none

package wakeupPkg;

    // Queue and lane sizes
    localparam int IQ_ENTRIES          = 16;
    localparam int ACTIVE_LIST_ENTRIES = 32;
    localparam int INT_LANES           = 2;
    localparam int MEM_LANES           = 2;
    localparam int LANES               = INT_LANES + MEM_LANES;

    // Execution latency of each lane class, in pipeline stages
    localparam int MEM_LATENCY = 3;
    localparam int INT_LATENCY = 1;

    typedef logic [$clog2(IQ_ENTRIES)-1:0]          iqIndex;
    typedef logic [IQ_ENTRIES-1:0]                  iqVector;
    typedef logic [$clog2(ACTIVE_LIST_ENTRIES)-1:0] activeListIndex;
    typedef logic [$clog2(MEM_LATENCY+1)-1:0]       flushCount;

    // One op picked by the select logic
    typedef struct packed {
        logic           selected;
        iqIndex         ptr;
        iqVector        depVector;
        activeListIndex alPtr;
    } selectReq;

    typedef struct packed {
        logic    wakeup;
        iqIndex  ptr;
        iqVector depVector;
    } wakeupResp;

    // Frees the issue-queue entry of a finished op
    typedef struct packed {
        logic   releaseEntry;
        iqIndex ptr;
    } releaseResp;

    typedef struct packed {
        logic           toRecovery;
        logic           fromRwStage;
        logic           flushAll;
        activeListIndex head;
        activeListIndex tail;
    } recoveryReq;

    // Active-list range whose in-flight ops must not wake consumers
    typedef struct packed {
        logic           active;
        logic           flushAll;
        activeListIndex head;
        activeListIndex tail;
    } flushWindow;

    // One pipeline register entry
    typedef struct packed {
        logic           valid;
        iqIndex         ptr;
        iqVector        depVector;
        activeListIndex alPtr;
    } laneStage;

    // True when ptr lies in [head, tail) of an active window, wrapping allowed
    function automatic logic inRange(input flushWindow window, input activeListIndex ptr);
        logic hit;
        if (!window.active) begin
            hit = 1'b0;
        end else if (window.flushAll) begin
            hit = 1'b1;
        end else if (window.head <= window.tail) begin
            hit = (ptr >= window.head) && (ptr < window.tail);
        end else begin
            hit = (ptr >= window.head) || (ptr < window.tail);
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// File: src/wakeupControl.sv
//**************************************************************************
// Wakeup recovery control
// Latches the selective flush range, runs the per-class flush-window
// counters and issues the full pipeline clear
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module wakeupControl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  wakeupPkg::recoveryReq  recovery,
    output logic                   clearPipes,
    output wakeupPkg::flushWindow  intWindow,
    output wakeupPkg::flushWindow  memWindow,
    output logic                   flushedOpExist
);

    logic                      rangeLoad;
    logic                      rangeFlushAll;
    wakeupPkg::activeListIndex rangeHead;
    wakeupPkg::activeListIndex rangeTail;
    wakeupPkg::flushCount      intCount;
    wakeupPkg::flushCount      memCount;

    // Counts down to zero, but the first step waits for a cycle without stall
    // since the op in the entry stage has not moved yet
    function automatic wakeupPkg::flushCount countDown(
        input wakeupPkg::flushCount count,
        input wakeupPkg::flushCount loadValue,
        input logic                 hold
    );
        wakeupPkg::flushCount result;
        if (count == '0) begin
            result = count;
        end else if (count == loadValue && hold) begin
            result = count;
        end else begin
            result = count - 1'b1;
        end
        return result;
    endfunction

    assign rangeLoad  = recovery.toRecovery && recovery.fromRwStage;
    assign clearPipes = recovery.toRecovery && !recovery.fromRwStage;

    always_ff @(posedge clock) begin
        if (reset) begin
            intCount <= '0;
            memCount <= '0;
        end else if (rangeLoad) begin
            intCount <= wakeupPkg::flushCount'(wakeupPkg::INT_LATENCY);
            memCount <= wakeupPkg::flushCount'(wakeupPkg::MEM_LATENCY);
        end else begin
            intCount <= countDown(intCount,
                wakeupPkg::flushCount'(wakeupPkg::INT_LATENCY), stall);
            memCount <= countDown(memCount,
                wakeupPkg::flushCount'(wakeupPkg::MEM_LATENCY), stall);
        end
    end

    // Flush range from the register-write stage
    always_ff @(posedge clock) begin
        if (rangeLoad) begin
            rangeHead     <= recovery.head;
            rangeTail     <= recovery.tail;
            rangeFlushAll <= recovery.flushAll;
        end
    end

    always_comb begin
        intWindow.active   = intCount != '0;
        intWindow.flushAll = rangeFlushAll;
        intWindow.head     = rangeHead;
        intWindow.tail     = rangeTail;

        memWindow.active   = memCount != '0;
        memWindow.flushAll = rangeFlushAll;
        memWindow.head     = rangeHead;
        memWindow.tail     = rangeTail;
    end

    assign flushedOpExist = intWindow.active || memWindow.active;

    // Counters only ever load their latency and count down from it
    counterBound: assert property (@(posedge clock) disable iff (reset)
        intCount <= wakeupPkg::INT_LATENCY && memCount <= wakeupPkg::MEM_LATENCY);

endmodule

`default_nettype wire

// File: src/intWakeupLane.sv
//**************************************************************************
// Integer wakeup lane
// Single-cycle delay for an integer op, with wakeup and release held
// back while the scheduler is stalled
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module intWakeupLane (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   clearPipes,
    input  wakeupPkg::selectReq    sel,
    input  wakeupPkg::iqVector     iqFlush,
    input  wakeupPkg::flushWindow  window,
    output wakeupPkg::wakeupResp   wake,
    output wakeupPkg::releaseResp  rel
);

    wakeupPkg::laneStage stage;
    wakeupPkg::laneStage nextStage;
    logic                flushed;

    // Entry flushed in the issue queue this cycle never enters
    always_comb begin
        nextStage.valid     = sel.selected && !iqFlush[sel.ptr];
        nextStage.ptr       = sel.ptr;
        nextStage.depVector = sel.depVector;
        nextStage.alPtr     = sel.alPtr;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stage <= '0;
        end else if (clearPipes) begin
            stage.valid <= 1'b0;
        end else if (!stall) begin
            stage <= nextStage;
        end
    end

    assign flushed = wakeupPkg::inRange(window, stage.alPtr);

    // Stalled cycle shows nothing, the op stays and leaves after the stall
    always_comb begin
        wake = '0;
        rel  = '0;
        if (!stall) begin
            wake.wakeup       = stage.valid && !flushed;
            wake.ptr          = stage.ptr;
            wake.depVector    = stage.depVector;
            rel.releaseEntry  = stage.valid;
            rel.ptr           = stage.ptr;
        end
    end

    // No consumer wakes up without its producer's entry being freed
    wakeImpliesRelease: assert property (@(posedge clock) disable iff (reset)
        wake.wakeup |-> rel.releaseEntry && rel.ptr == wake.ptr);

endmodule

`default_nettype wire

// File: src/memWakeupLane.sv
//**************************************************************************
// Memory wakeup lane
// Shift chain of MEM_LATENCY stages for a memory op; under stall only the
// entry stage holds and a bubble goes into the stage behind it
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module memWakeupLane (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  logic                   clearPipes,
    input  wakeupPkg::selectReq    sel,
    input  wakeupPkg::iqVector     iqFlush,
    input  wakeupPkg::flushWindow  window,
    output wakeupPkg::wakeupResp   wake,
    output wakeupPkg::releaseResp  rel
);

    // Stage MEM_LATENCY-1 is the entry, stage 0 is the exit
    wakeupPkg::laneStage stages [wakeupPkg::MEM_LATENCY];
    wakeupPkg::laneStage nextStage;
    logic                flushed;

    always_comb begin
        nextStage.valid     = sel.selected && !iqFlush[sel.ptr];
        nextStage.ptr       = sel.ptr;
        nextStage.depVector = sel.depVector;
        nextStage.alPtr     = sel.alPtr;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < wakeupPkg::MEM_LATENCY; j++) begin
                stages[j] <= '0;
            end
        end else if (clearPipes) begin
            for (int j = 0; j < wakeupPkg::MEM_LATENCY; j++) begin
                stages[j].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int j = 1; j < wakeupPkg::MEM_LATENCY; j++) begin
                stages[j-1] <= stages[j];
            end
            stages[wakeupPkg::MEM_LATENCY-1] <= nextStage;
        end else begin
            // Older stages keep draining toward the exit
            for (int j = 1; j < wakeupPkg::MEM_LATENCY - 1; j++) begin
                stages[j-1] <= stages[j];
            end
            // Entry holds its op, so the next stage gets a bubble
            stages[wakeupPkg::MEM_LATENCY-2].valid     <= 1'b0;
            stages[wakeupPkg::MEM_LATENCY-2].depVector <= '0;
        end
    end

    assign flushed = wakeupPkg::inRange(window, stages[0].alPtr);

    // Memory exit is not gated by stall
    always_comb begin
        wake.wakeup      = stages[0].valid && !flushed;
        wake.ptr         = stages[0].ptr;
        wake.depVector   = stages[0].depVector;
        rel.releaseEntry = stages[0].valid;
        rel.ptr          = stages[0].ptr;
    end

    // A stalled entry stage must not duplicate its op downstream
    bubbleAfterStall: assert property (@(posedge clock) disable iff (reset)
        stall |=> !stages[wakeupPkg::MEM_LATENCY-2].valid);

endmodule

`default_nettype wire

// File: src/wakeupPipeline.sv
//**************************************************************************
// Issue-queue wakeup pipeline
// Spreads selected ops over the integer and memory lanes and connects the
// recovery control that clears the lanes and masks flushed wakeups
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module wakeupPipeline (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   stall,
    input  wakeupPkg::selectReq    sel [wakeupPkg::LANES],
    input  wakeupPkg::iqVector     iqFlush,
    input  wakeupPkg::recoveryReq  recovery,
    output wakeupPkg::wakeupResp   wake [wakeupPkg::LANES],
    output wakeupPkg::releaseResp  rel [wakeupPkg::LANES],
    output logic                   flushedOpExist
);

    logic                  clearPipes;
    wakeupPkg::flushWindow intWindow;
    wakeupPkg::flushWindow memWindow;

    wakeupControl i_control (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .recovery       (recovery),
        .clearPipes     (clearPipes),
        .intWindow      (intWindow),
        .memWindow      (memWindow),
        .flushedOpExist (flushedOpExist)
    );

    // Integer lanes take the low lane indices
    for (genvar i = 0; i < wakeupPkg::INT_LANES; i++) begin : genIntLane
        intWakeupLane i_intWakeupLane (
            .clock      (clock),
            .reset      (reset),
            .stall      (stall),
            .clearPipes (clearPipes),
            .sel        (sel[i]),
            .iqFlush    (iqFlush),
            .window     (intWindow),
            .wake       (wake[i]),
            .rel        (rel[i])
        );
    end

    // Memory lanes follow the integer lanes
    for (genvar i = 0; i < wakeupPkg::MEM_LANES; i++) begin : genMemLane
        memWakeupLane i_memWakeupLane (
            .clock      (clock),
            .reset      (reset),
            .stall      (stall),
            .clearPipes (clearPipes),
            .sel        (sel[wakeupPkg::INT_LANES + i]),
            .iqFlush    (iqFlush),
            .window     (memWindow),
            .wake       (wake[wakeupPkg::INT_LANES + i]),
            .rel        (rel[wakeupPkg::INT_LANES + i])
        );
    end

endmodule

`default_nettype wire

// File: sim/wakeupTbTasks.svh
//****************************************************************************
// Wakeup pipeline testbench tasks
// Stimulus helpers, compare tasks and the directed tests
//****************************************************************************

`ifndef WAKEUP_TB_TASKS_SVH
`define WAKEUP_TB_TASKS_SVH

task automatic failRun(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error");
endtask

task automatic compareWakeup(input string name, input wakeupPkg::wakeupResp actual,
                             input wakeupPkg::wakeupResp expected);
    if (actual !== expected) begin
        failRun($sformatf("[FAIL] %0t %s expected %h actual %h",
            $time, name, expected, actual));
    end
endtask

task automatic compareRelease(input string name, input wakeupPkg::releaseResp actual,
                              input wakeupPkg::releaseResp expected);
    if (actual !== expected) begin
        failRun($sformatf("[FAIL] %0t %s expected %h actual %h",
            $time, name, expected, actual));
    end
endtask

task automatic compareBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        failRun($sformatf("[FAIL] %0t %s expected %b actual %b",
            $time, name, expected, actual));
    end
endtask

task automatic randomOp(output wakeupPkg::selectReq op);
    op.selected  = 1'b1;
    op.ptr       = wakeupPkg::iqIndex'($random(seed));
    op.depVector = wakeupPkg::iqVector'($random(seed));
    op.alPtr     = wakeupPkg::activeListIndex'($random(seed));
endtask

task automatic clearInputs;
    for (int i = 0; i < wakeupPkg::LANES; i++) begin
        sel[i] <= '0;
    end
    iqFlush  <= '0;
    recovery <= '0;
endtask

// Waits at falling edges for a release and checks how many cycles it took
task automatic waitRelease(input int lane, input int expected);
    int cycles;
    cycles = 0;
    do begin
        @(negedge clock);
        cycles++;
    end while (!rel[lane].releaseEntry && cycles < expected + 2);
    if (!rel[lane].releaseEntry) begin
        failRun($sformatf("Timed out waiting for a release on lane %0d", lane));
    end else if (cycles != expected) begin
        failRun($sformatf("Lane %0d released after %0d cycles instead of %0d",
            lane, cycles, expected));
    end
endtask

task automatic waitFlushClear(input int limit, input int elapsed);
    int cycles;
    cycles = elapsed;
    while (flushedOpExist && cycles < limit) begin
        @(negedge clock);
        cycles++;
    end
    if (flushedOpExist) begin
        failRun("flushedOpExist stayed high too long after selective recovery");
    end
endtask

// Output of a finished op, with or without its wakeup
task automatic checkOp(input int lane, input wakeupPkg::selectReq op, input logic expectWake);
    wakeupPkg::wakeupResp  expWake;
    wakeupPkg::releaseResp expRel;
    expWake.wakeup       = 1'b1;
    expWake.ptr          = op.ptr;
    expWake.depVector    = op.depVector;
    expRel.releaseEntry  = 1'b1;
    expRel.ptr           = op.ptr;
    if (expectWake) begin
        compareWakeup($sformatf("wake[%0d]", lane), wake[lane], expWake);
    end else begin
        compareBit($sformatf("wake[%0d].wakeup", lane), wake[lane].wakeup, 1'b0);
    end
    compareRelease($sformatf("rel[%0d]", lane), rel[lane], expRel);
endtask

task automatic checkQuiet;
    for (int i = 0; i < wakeupPkg::LANES; i++) begin
        compareBit($sformatf("wake[%0d].wakeup", i), wake[i].wakeup, 1'b0);
        compareBit($sformatf("rel[%0d].releaseEntry", i), rel[i].releaseEntry, 1'b0);
    end
    compareBit("flushedOpExist", flushedOpExist, 1'b0);
endtask

task automatic intTest;
    wakeupPkg::selectReq ops [wakeupPkg::INT_LANES];
    @(posedge clock);
    for (int i = 0; i < wakeupPkg::INT_LANES; i++) begin
        randomOp(ops[i]);
        sel[i] <= ops[i];
    end
    @(posedge clock);
    clearInputs();
    waitRelease(0, wakeupPkg::INT_LATENCY);
    for (int i = 0; i < wakeupPkg::INT_LANES; i++) begin
        checkOp(i, ops[i], 1'b1);
    end
    @(negedge clock);
    checkQuiet();
endtask

task automatic memTest(input int lane);
    wakeupPkg::selectReq ops [wakeupPkg::MEM_LATENCY];
    for (int k = 0; k < wakeupPkg::MEM_LATENCY; k++) begin
        @(posedge clock);
        randomOp(ops[k]);
        sel[lane] <= ops[k];
    end
    @(posedge clock);
    clearInputs();
    // First op reaches the exit on the last select edge, the rest follow each cycle
    for (int k = 0; k < wakeupPkg::MEM_LATENCY; k++) begin
        waitRelease(lane, 1);
        checkOp(lane, ops[k], 1'b1);
    end
    @(negedge clock);
    checkQuiet();
endtask

task automatic stallTest(input int stallCycles);
    wakeupPkg::selectReq intOp;
    wakeupPkg::selectReq memOp;
    @(posedge clock);
    randomOp(intOp);
    randomOp(memOp);
    sel[0]                   <= intOp;
    sel[wakeupPkg::INT_LANES] <= memOp;
    @(posedge clock);
    clearInputs();
    stall <= 1'b1;
    for (int s = 0; s < stallCycles; s++) begin
        @(negedge clock);
        compareWakeup("wake[0]", wake[0], '0);
        compareRelease("rel[0]", rel[0], '0);
        @(posedge clock);
    end
    stall <= 1'b0;
    waitRelease(0, wakeupPkg::INT_LATENCY);
    checkOp(0, intOp, 1'b1);
    // Memory op sat in the entry stage for every stall cycle
    waitRelease(wakeupPkg::INT_LANES, wakeupPkg::MEM_LATENCY - wakeupPkg::INT_LATENCY);
    checkOp(wakeupPkg::INT_LANES, memOp, 1'b1);
endtask

task automatic flushTest;
    wakeupPkg::selectReq intOp;
    wakeupPkg::selectReq memOp;
    @(posedge clock);
    randomOp(intOp);
    randomOp(memOp);
    sel[0]                   <= intOp;
    sel[wakeupPkg::INT_LANES] <= memOp;
    iqFlush <= (wakeupPkg::iqVector'(1) << intOp.ptr) | (wakeupPkg::iqVector'(1) << memOp.ptr);
    @(posedge clock);
    clearInputs();
    repeat (wakeupPkg::MEM_LATENCY + 2) begin
        @(negedge clock);
        checkQuiet();
    end
endtask

// Even lanes carry inAl and odd lanes outAl
task automatic recoveryTest(input wakeupPkg::activeListIndex head,
                            input wakeupPkg::activeListIndex tail,
                            input wakeupPkg::activeListIndex inAl,
                            input wakeupPkg::activeListIndex outAl);
    wakeupPkg::selectReq   ops [wakeupPkg::LANES];
    wakeupPkg::recoveryReq req;
    @(posedge clock);
    for (int i = 0; i < wakeupPkg::LANES; i++) begin
        randomOp(ops[i]);
        ops[i].alPtr = (i % 2 == 0) ? inAl : outAl;
        sel[i] <= ops[i];
    end
    req             = '0;
    req.toRecovery  = 1'b1;
    req.fromRwStage = 1'b1;
    req.head        = head;
    req.tail        = tail;
    recovery <= req;
    @(posedge clock);
    clearInputs();
    waitRelease(0, wakeupPkg::INT_LATENCY);
    compareBit("flushedOpExist", flushedOpExist, 1'b1);
    for (int i = 0; i < wakeupPkg::INT_LANES; i++) begin
        checkOp(i, ops[i], i % 2 != 0);
    end
    waitRelease(wakeupPkg::INT_LANES, wakeupPkg::MEM_LATENCY - wakeupPkg::INT_LATENCY);
    for (int i = wakeupPkg::INT_LANES; i < wakeupPkg::LANES; i++) begin
        checkOp(i, ops[i], i % 2 != 0);
    end
    waitFlushClear(wakeupPkg::MEM_LATENCY + 1, wakeupPkg::MEM_LATENCY);
endtask

task automatic fullRecoveryTest;
    wakeupPkg::selectReq   op;
    wakeupPkg::recoveryReq req;
    @(posedge clock);
    for (int i = wakeupPkg::INT_LANES; i < wakeupPkg::LANES; i++) begin
        randomOp(op);
        sel[i] <= op;
    end
    @(posedge clock);
    clearInputs();
    req            = '0;
    req.toRecovery = 1'b1;
    recovery <= req;
    @(posedge clock);
    clearInputs();
    repeat (wakeupPkg::MEM_LATENCY + 2) begin
        @(negedge clock);
        checkQuiet();
    end
    intTest();
endtask

`endif

// File: sim/wakeupPipelineTb.sv
//****************************************************************************
// Wakeup pipeline testbench
// Drives the wakeup pipeline through directed tests for the integer and
// memory lanes, stall, entry flush and both kinds of recovery
//****************************************************************************

`timescale 1ns/1ps
`default_nettype none

module wakeupPipelineTb;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  stall;
    wakeupPkg::selectReq   sel [wakeupPkg::LANES];
    wakeupPkg::iqVector    iqFlush;
    wakeupPkg::recoveryReq recovery;
    wakeupPkg::wakeupResp  wake [wakeupPkg::LANES];
    wakeupPkg::releaseResp rel [wakeupPkg::LANES];
    logic                  flushedOpExist;

    integer seed;

    wakeupPipeline i_wakeupPipeline (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .sel            (sel),
        .iqFlush        (iqFlush),
        .recovery       (recovery),
        .wake           (wake),
        .rel            (rel),
        .flushedOpExist (flushedOpExist)
    );

    // 20 ns clock period
    always #10 clock = ~clock;

    `include "wakeupTbTasks.svh"

    initial begin
        seed       = 32'h3ef2;
        reset      = 1'b1;
        stall      = 1'b0;
        iqFlush    = '0;
        recovery   = '0;
        for (int i = 0; i < wakeupPkg::LANES; i++) begin
            sel[i] = '0;
        end

        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checkQuiet();

        intTest();
        for (int i = wakeupPkg::INT_LANES; i < wakeupPkg::LANES; i++) begin
            memTest(i);
        end
        stallTest(1);
        stallTest(4);
        flushTest();

        // Plain range with its tail just outside, then a wrapping range
        recoveryTest(5'd4, 5'd12, 5'd7, 5'd12);
        recoveryTest(5'd28, 5'd3, 5'd1, 5'd20);
        fullRecoveryTest();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+sim
src/wakeupPkg.sv
src/wakeupControl.sv
src/intWakeupLane.sv
src/memWakeupLane.sv
src/wakeupPipeline.sv
sim/wakeupPipelineTb.sv

// File: Bender.yml
package:
  name: wakeup_pipeline

sources:
  - files:
      - src/wakeupPkg.sv
      - src/wakeupControl.sv
      - src/intWakeupLane.sv
      - src/memWakeupLane.sv
      - src/wakeupPipeline.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/wakeupPipelineTb.sv
